// ==== exmem_slice.f ====
+incdir+logic
logic/exmem_pkg.sv
logic/dmem_if.sv
logic/ex_mem_reg.sv
logic/load_store_unit.sv
logic/dmem_arbiter.sv
logic/data_ram.sv
logic/exmem_slice.sv
testbench/exmem_slice_props.sv
testbench/exmem_slice_tb.sv

// ==== logic/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exmem_cfg.svh"

module data_ram (
	input  logic                     clk,
	input  logic                     en,
	input  logic                     we,
	input  logic [`EXMEM_RAM_AW-1:0] addr,
	input  logic [`EXMEM_BE_W-1:0]   be,
	input  logic [`EXMEM_DATA_W-1:0] wdata,
	output logic [`EXMEM_DATA_W-1:0] rdata
);

	logic [`EXMEM_DATA_W-1:0] mem [0:`EXMEM_RAM_DEPTH-1];

	// read data appears one cycle after an enabled read.
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				for (int i = 0; i < `EXMEM_BE_W; i++) begin
					if (be[i]) begin
						mem[addr][8*i +: 8] <= wdata[8*i +: 8];
					end
				end
			end else begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/dmem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exmem_cfg.svh"

module dmem_arbiter (
	input  logic                     clk,
	input  logic                     reset_n,
	dmem_if.arbiter                  lsu,
	dmem_if.arbiter                  host,
	output logic                     ram_en,
	output logic                     ram_we,
	output logic [`EXMEM_RAM_AW-1:0] ram_addr,
	output logic [`EXMEM_BE_W-1:0]   ram_be,
	output logic [`EXMEM_DATA_W-1:0] ram_wdata,
	input  logic [`EXMEM_DATA_W-1:0] ram_rdata
);

	logic lsu_gnt;
	logic host_gnt;
	logic last_host;
	logic lsu_rd;
	logic host_rd;

	// on a tie the port that lost last time wins.
	assign lsu_gnt  = lsu.req && (!host.req || last_host);
	assign host_gnt = host.req && !lsu_gnt;

	assign lsu.gnt  = lsu_gnt;
	assign host.gnt = host_gnt;

	always_comb begin
		ram_en = lsu_gnt || host_gnt;
		if (host_gnt) begin
			ram_we    = host.we;
			ram_addr  = host.addr;
			ram_be    = host.be;
			ram_wdata = host.wdata;
		end else begin
			ram_we    = lsu.we && lsu_gnt;
			ram_addr  = lsu.addr;
			ram_be    = lsu.be;
			ram_wdata = lsu.wdata;
		end
	end

	// last_host starts high so the load/store unit takes the first tie.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			last_host <= 1'b1;
			lsu_rd    <= 1'b0;
			host_rd   <= 1'b0;
		end else begin
			if (ram_en) begin
				last_host <= host_gnt;
			end
			lsu_rd  <= lsu_gnt && !lsu.we;
			host_rd <= host_gnt && !host.we;
		end
	end

	assign lsu.rvalid  = lsu_rd;
	assign lsu.rdata   = ram_rdata;
	assign host.rvalid = host_rd;
	assign host.rdata  = ram_rdata;

endmodule

`default_nettype wire

// ==== logic/dmem_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exmem_cfg.svh"

interface dmem_if;

	logic                       req;
	logic                       we;
	logic [`EXMEM_RAM_AW-1:0]   addr;
	logic [`EXMEM_BE_W-1:0]     be;
	logic [`EXMEM_DATA_W-1:0]   wdata;
	logic                       gnt;
	logic [`EXMEM_DATA_W-1:0]   rdata;
	logic                       rvalid;

	// the requester keeps req and its fields stable until gnt.
	modport requester (
		output req, we, addr, be, wdata,
		input  gnt, rdata, rvalid
	);

	modport arbiter (
		input  req, we, addr, be, wdata,
		output gnt, rdata, rvalid
	);

endinterface

`default_nettype wire

// ==== logic/ex_mem_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  stall,
	input  exmem_pkg::ex_result_t ex_in,
	output exmem_pkg::ex_result_t mem_out
);

	// an all-zero record is an invalid NOP.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			mem_out <= '0;
		end else if (!stall) begin
			mem_out <= ex_in;
		end
	end

endmodule

`default_nettype wire

// ==== logic/exmem_cfg.svh ====
`ifndef EXMEM_CFG_SVH
`define EXMEM_CFG_SVH

// data path and byte address width of the integer pipeline.
`define EXMEM_DATA_W 32

// byte lanes in one data word.
`define EXMEM_BE_W 4

// register file address width.
`define EXMEM_REG_ADDR_W 5

// the data RAM holds 256 words.
`define EXMEM_RAM_AW 8
`define EXMEM_RAM_DEPTH (1 << `EXMEM_RAM_AW)

`endif

// ==== logic/exmem_pkg.sv ====
`default_nettype none
`include "exmem_cfg.svh"

package exmem_pkg;

	// operation carried from execute into the memory stage.
	typedef enum logic [3:0] {
		NOP    = 4'd0,
		ALU    = 4'd1,
		MTHILO = 4'd2,
		LB     = 4'd3,
		LBU    = 4'd4,
		LH     = 4'd5,
		LHU    = 4'd6,
		LW     = 4'd7,
		SB     = 4'd8,
		SH     = 4'd9,
		SW     = 4'd10
	} mem_op_e;

	typedef enum logic [1:0] {
		IDLE      = 2'd0,
		WAIT_GNT  = 2'd1,
		WAIT_DATA = 2'd2
	} lsu_state_e;

	typedef struct packed {
		logic                         valid;
		mem_op_e                      op;
		logic [`EXMEM_REG_ADDR_W-1:0] waddr;
		logic [`EXMEM_DATA_W-1:0]     wdata;
		logic [`EXMEM_DATA_W-1:0]     hi;
		logic [`EXMEM_DATA_W-1:0]     lo;
		logic [`EXMEM_DATA_W-1:0]     ram_addr;
		logic [`EXMEM_DATA_W-1:0]     reg2;
	} ex_result_t;

	typedef struct packed {
		logic                         valid;
		logic                         we;
		logic [`EXMEM_REG_ADDR_W-1:0] waddr;
		logic [`EXMEM_DATA_W-1:0]     wdata;
		logic                         whilo;
		logic [`EXMEM_DATA_W-1:0]     hi;
		logic [`EXMEM_DATA_W-1:0]     lo;
	} wb_result_t;

endpackage

`default_nettype wire

// ==== logic/exmem_slice.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exmem_cfg.svh"

module exmem_slice (
	input  logic                         clk,
	input  logic                         reset_n,
	input  logic                         ex_valid,
	input  exmem_pkg::mem_op_e           ex_op,
	input  logic [`EXMEM_REG_ADDR_W-1:0] ex_waddr,
	input  logic [`EXMEM_DATA_W-1:0]     ex_wdata,
	input  logic [`EXMEM_DATA_W-1:0]     ex_hi,
	input  logic [`EXMEM_DATA_W-1:0]     ex_lo,
	input  logic [`EXMEM_DATA_W-1:0]     ex_ram_addr,
	input  logic [`EXMEM_DATA_W-1:0]     ex_reg2,
	output logic                         stall,
	output logic                         wb_valid,
	output logic                         wb_we,
	output logic [`EXMEM_REG_ADDR_W-1:0] wb_waddr,
	output logic [`EXMEM_DATA_W-1:0]     wb_wdata,
	output logic                         wb_whilo,
	output logic [`EXMEM_DATA_W-1:0]     wb_hi,
	output logic [`EXMEM_DATA_W-1:0]     wb_lo,
	input  logic                         host_req,
	input  logic                         host_we,
	input  logic [`EXMEM_RAM_AW-1:0]     host_addr,
	input  logic [`EXMEM_BE_W-1:0]       host_be,
	input  logic [`EXMEM_DATA_W-1:0]     host_wdata,
	output logic                         host_gnt,
	output logic [`EXMEM_DATA_W-1:0]     host_rdata,
	output logic                         host_rvalid
);

	import exmem_pkg::*;

	ex_result_t               ex_in;
	ex_result_t               mem_in;
	wb_result_t               wb;
	logic                     ram_en;
	logic                     ram_we;
	logic [`EXMEM_RAM_AW-1:0] ram_addr;
	logic [`EXMEM_BE_W-1:0]   ram_be;
	logic [`EXMEM_DATA_W-1:0] ram_wdata;
	logic [`EXMEM_DATA_W-1:0] ram_rdata;

	dmem_if lsu_port ();
	dmem_if host_port ();

	assign ex_in = '{valid: ex_valid, op: ex_op, waddr: ex_waddr, wdata: ex_wdata,
		hi: ex_hi, lo: ex_lo, ram_addr: ex_ram_addr, reg2: ex_reg2};

	assign host_port.req   = host_req;
	assign host_port.we    = host_we;
	assign host_port.addr  = host_addr;
	assign host_port.be    = host_be;
	assign host_port.wdata = host_wdata;
	assign host_gnt        = host_port.gnt;
	assign host_rdata      = host_port.rdata;
	assign host_rvalid     = host_port.rvalid;

	ex_mem_reg i_ex_mem_reg (.clk, .reset_n, .stall, .ex_in, .mem_out(mem_in));

	load_store_unit i_load_store_unit (.clk, .reset_n, .mem_in, .stall,
		.dmem(lsu_port), .wb_out(wb));

	dmem_arbiter i_dmem_arbiter (.clk, .reset_n, .lsu(lsu_port), .host(host_port),
		.ram_en, .ram_we, .ram_addr, .ram_be, .ram_wdata, .ram_rdata);

	data_ram i_data_ram (.clk, .en(ram_en), .we(ram_we), .addr(ram_addr), .be(ram_be),
		.wdata(ram_wdata), .rdata(ram_rdata));

	assign wb_valid = wb.valid;
	assign wb_we    = wb.we;
	assign wb_waddr = wb.waddr;
	assign wb_wdata = wb.wdata;
	assign wb_whilo = wb.whilo;
	assign wb_hi    = wb.hi;
	assign wb_lo    = wb.lo;

endmodule

`default_nettype wire

// ==== logic/load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exmem_cfg.svh"

module load_store_unit (
	input  logic                  clk,
	input  logic                  reset_n,
	input  exmem_pkg::ex_result_t mem_in,
	output logic                  stall,
	dmem_if.requester             dmem,
	output exmem_pkg::wb_result_t wb_out
);

	import exmem_pkg::*;

	lsu_state_e                state;
	lsu_state_e                state_nxt;
	logic                      is_load;
	logic                      is_store;
	logic                      is_mem;
	logic                      done;
	logic [1:0]                lane;
	logic [7:0]                ld_byte;
	logic [15:0]               ld_half;
	logic [`EXMEM_DATA_W-1:0]  ld_data;
	wb_result_t                wb_nxt;

	assign is_load  = mem_in.valid && (mem_in.op inside {LB, LBU, LH, LHU, LW});
	assign is_store = mem_in.valid && (mem_in.op inside {SB, SH, SW});
	assign is_mem   = is_load || is_store;
	assign lane     = mem_in.ram_addr[1:0];

	// the request stays up from the first cycle in EX/MEM until it is granted.
	assign dmem.req  = is_mem && (state != WAIT_DATA);
	assign dmem.we   = is_store;
	assign dmem.addr = mem_in.ram_addr[`EXMEM_RAM_AW+1:2];

	always_comb begin
		dmem.be    = 4'b1111;
		dmem.wdata = mem_in.reg2;
		case (mem_in.op)
			SB: begin
				dmem.be    = 4'b0001 << lane;
				dmem.wdata = {4{mem_in.reg2[7:0]}};
			end
			SH: begin
				dmem.be    = lane[1] ? 4'b1100 : 4'b0011;
				dmem.wdata = {2{mem_in.reg2[15:0]}};
			end
			default: begin
			end
		endcase
	end

	// a store finishes on its grant, a load when its data returns.
	assign done  = is_store ? dmem.gnt : ((state == WAIT_DATA) && dmem.rvalid);
	assign stall = is_mem && !done;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE, WAIT_GNT: begin
				if (!is_mem) begin
					state_nxt = IDLE;
				end else if (dmem.gnt) begin
					state_nxt = is_load ? WAIT_DATA : IDLE;
				end else begin
					state_nxt = WAIT_GNT;
				end
			end
			WAIT_DATA: begin
				if (dmem.rvalid) begin
					state_nxt = IDLE;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	assign ld_byte = dmem.rdata[8*lane +: 8];
	assign ld_half = lane[1] ? dmem.rdata[31:16] : dmem.rdata[15:0];

	always_comb begin
		case (mem_in.op)
			LB:      ld_data = {{24{ld_byte[7]}}, ld_byte};
			LBU:     ld_data = {24'd0, ld_byte};
			LH:      ld_data = {{16{ld_half[15]}}, ld_half};
			LHU:     ld_data = {16'd0, ld_half};
			default: ld_data = dmem.rdata;
		endcase
	end

	// one record leaves per op, on the edge where the stage lets it go.
	always_comb begin
		wb_nxt       = '0;
		wb_nxt.valid = mem_in.valid && !stall;
		wb_nxt.we    = wb_nxt.valid && (is_load || (mem_in.op == ALU));
		wb_nxt.whilo = wb_nxt.valid && (mem_in.op == MTHILO);
		wb_nxt.waddr = mem_in.waddr;
		wb_nxt.wdata = is_load ? ld_data : mem_in.wdata;
		wb_nxt.hi    = mem_in.hi;
		wb_nxt.lo    = mem_in.lo;
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wb_out <= '0;
		end else begin
			wb_out <= wb_nxt;
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the exmem_slice testbench with Verilator and runs it into a log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f exmem_slice.f --top-module exmem_slice_tb -o exmem_slice_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/exmem_slice_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== testbench/exmem_slice_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module exmem_slice_props (
	input logic               clk,
	input logic               reset_n,
	input logic               stall,
	input logic               mem_valid,
	input exmem_pkg::mem_op_e mem_op,
	input logic               lsu_gnt,
	input logic               lsu_we,
	input logic               lsu_rvalid,
	input logic               host_gnt,
	input logic               host_we,
	input logic               host_rvalid,
	input logic               wb_valid
);

	import exmem_pkg::*;

	int fail_count = 0;

	// a non-memory op never holds up the execute side.
	stall_needs_mem_op: assert property (@(posedge clk) disable iff (!reset_n)
		stall |-> (mem_valid && !(mem_op inside {NOP, ALU, MTHILO})))
	else begin
		$error("stall is high while EX/MEM holds no memory op");
		fail_count++;
	end

	one_grant: assert property (@(posedge clk) disable iff (!reset_n)
		!(lsu_gnt && host_gnt))
	else begin
		$error("both ports granted in one cycle");
		fail_count++;
	end

	// read data returns exactly one cycle after the read grant.
	lsu_read_return: assert property (@(posedge clk) disable iff (!reset_n)
		lsu_rvalid == $past(lsu_gnt && !lsu_we))
	else begin
		$error("lsu rvalid does not follow its read grant by one cycle");
		fail_count++;
	end

	host_read_return: assert property (@(posedge clk) disable iff (!reset_n)
		host_rvalid == $past(host_gnt && !host_we))
	else begin
		$error("host rvalid does not follow its read grant by one cycle");
		fail_count++;
	end

	wb_quiet_in_reset: assert property (@(posedge clk) !reset_n |-> !wb_valid)
	else begin
		$error("wb_valid is high during reset");
		fail_count++;
	end

endmodule

`default_nettype wire

// ==== testbench/exmem_slice_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exmem_cfg.svh"

module exmem_slice_tb;

	import exmem_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int TABLE_LEN = 24;
	localparam int CYCLE_LIMIT = 20 * TABLE_LEN + RESET_CYCLES;

	typedef struct packed {
		logic                         valid;
		mem_op_e                      op;
		logic [`EXMEM_REG_ADDR_W-1:0] waddr;
		logic [`EXMEM_DATA_W-1:0]     wdata;
		logic [`EXMEM_DATA_W-1:0]     hi;
		logic [`EXMEM_DATA_W-1:0]     lo;
		logic [`EXMEM_DATA_W-1:0]     addr;
		logic [`EXMEM_DATA_W-1:0]     reg2;
		logic [`EXMEM_DATA_W-1:0]     exp;
	} entry_t;

	logic                         clk;
	logic                         reset_n;
	logic                         ex_valid;
	mem_op_e                      ex_op;
	logic [`EXMEM_REG_ADDR_W-1:0] ex_waddr;
	logic [`EXMEM_DATA_W-1:0]     ex_wdata;
	logic [`EXMEM_DATA_W-1:0]     ex_hi;
	logic [`EXMEM_DATA_W-1:0]     ex_lo;
	logic [`EXMEM_DATA_W-1:0]     ex_ram_addr;
	logic [`EXMEM_DATA_W-1:0]     ex_reg2;
	logic                         stall;
	logic                         wb_valid;
	logic                         wb_we;
	logic [`EXMEM_REG_ADDR_W-1:0] wb_waddr;
	logic [`EXMEM_DATA_W-1:0]     wb_wdata;
	logic                         wb_whilo;
	logic [`EXMEM_DATA_W-1:0]     wb_hi;
	logic [`EXMEM_DATA_W-1:0]     wb_lo;
	logic                         host_req;
	logic                         host_we;
	logic [`EXMEM_RAM_AW-1:0]     host_addr;
	logic [`EXMEM_BE_W-1:0]       host_be;
	logic [`EXMEM_DATA_W-1:0]     host_wdata;
	logic                         host_gnt;
	logic [`EXMEM_DATA_W-1:0]     host_rdata;
	logic                         host_rvalid;

	entry_t                   tbl [0:TABLE_LEN-1];
	int                       n_fill;
	logic [`EXMEM_DATA_W-1:0] ram_model [0:`EXMEM_RAM_DEPTH-1];
	logic [`EXMEM_RAM_DEPTH-1:0] known;
	wb_result_t               exp_q [$];
	int                       due_q [$];
	int                       n_checked;
	int                       cycle;
	logic [31:0]              lfsr;
	logic                     bg_on;

	exmem_slice i_exmem_slice (.*);

	bind exmem_slice exmem_slice_props i_props (
		.clk, .reset_n, .stall,
		.mem_valid(mem_in.valid), .mem_op(mem_in.op),
		.lsu_gnt(lsu_port.gnt), .lsu_we(lsu_port.we), .lsu_rvalid(lsu_port.rvalid),
		.host_gnt, .host_we, .host_rvalid, .wb_valid
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic take_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) begin
			lfsr = lfsr ^ 32'ha300_0000;
		end
		return b;
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], take_bit()};
		end
		return v;
	endfunction

	task automatic report_error(input string line);
		$display("%s", line);
		$display("Result: FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_error($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
				$time, name, got, exp));
		end
	endtask

	task automatic check_word(input logic [`EXMEM_RAM_AW-1:0] addr,
		input logic [`EXMEM_DATA_W-1:0] got, input logic [`EXMEM_DATA_W-1:0] exp);
		if (got !== exp) begin
			report_error($sformatf(
				"CHECK FAILED at %0t: host read of word %0h gave %h, expected %h",
				$time, addr, got, exp));
		end
	endtask

	// only the fields that the enables make meaningful are compared.
	task automatic check_wb(input wb_result_t got, input wb_result_t exp);
		if (got.we !== exp.we || got.whilo !== exp.whilo ||
			(exp.we && (got.waddr !== exp.waddr || got.wdata !== exp.wdata)) ||
			(exp.whilo && (got.hi !== exp.hi || got.lo !== exp.lo))) begin
			report_error($sformatf("CHECK FAILED at %0t: writeback %p, expected %p",
				$time, got, exp));
		end
	endtask

	task automatic model_store(input mem_op_e op, input logic [`EXMEM_DATA_W-1:0] addr,
		input logic [`EXMEM_DATA_W-1:0] data);
		logic [`EXMEM_RAM_AW-1:0] w;
		w = addr[`EXMEM_RAM_AW+1:2];
		case (op)
			SB: ram_model[w][8*addr[1:0] +: 8] = data[7:0];
			SH: ram_model[w][16*addr[1] +: 16] = data[15:0];
			default: ram_model[w] = data;
		endcase
		known[w] = 1'b1;
	endtask

	task automatic add_entry(input logic valid, input mem_op_e op,
		input logic [`EXMEM_REG_ADDR_W-1:0] waddr, input logic [31:0] wdata,
		input logic [31:0] hi, input logic [31:0] lo, input logic [31:0] addr,
		input logic [31:0] reg2, input logic [31:0] exp);
		tbl[n_fill] = '{valid, op, waddr, wdata, hi, lo, addr, reg2, exp};
		n_fill++;
	endtask

	// word 4 is preloaded by the host with f0e1_d2c3 before the table runs.
	task automatic fill_table();
		n_fill = 0;
		add_entry(1, ALU,    5'd1,  32'h1234_5678, 0, 0, 0, 0, 32'h1234_5678);
		add_entry(1, MTHILO, 5'd0,  0, 32'ha5a5_0001, 32'h5a5a_0002, 0, 0, 0);
		add_entry(0, ALU,    5'd2,  32'h0bad_0bad, 0, 0, 0, 0, 0);
		add_entry(1, SW,     5'd0,  0, 0, 0, 32'h00, 32'hdead_beef, 0);
		add_entry(1, LW,     5'd3,  0, 0, 0, 32'h00, 0, 32'hdead_beef);
		add_entry(1, SW,     5'd0,  0, 0, 0, 32'h04, 32'h1122_3344, 0);
		add_entry(1, SB,     5'd0,  0, 0, 0, 32'h05, 32'h0000_00ab, 0);
		add_entry(1, SH,     5'd0,  0, 0, 0, 32'h06, 32'h0000_cdef, 0);
		add_entry(1, LW,     5'd4,  0, 0, 0, 32'h04, 0, 32'hcdef_ab44);
		add_entry(1, SW,     5'd0,  0, 0, 0, 32'h08, 32'h0102_0304, 0);
		add_entry(1, SB,     5'd0,  0, 0, 0, 32'h0b, 32'h0000_0077, 0);
		add_entry(1, LW,     5'd5,  0, 0, 0, 32'h08, 0, 32'h7702_0304);
		add_entry(1, LB,     5'd6,  0, 0, 0, 32'h09, 0, 32'h0000_0003);
		add_entry(1, LB,     5'd7,  0, 0, 0, 32'h0b, 0, 32'h0000_0077);
		add_entry(1, LB,     5'd8,  0, 0, 0, 32'h10, 0, 32'hffff_ffc3);
		add_entry(1, LBU,    5'd10, 0, 0, 0, 32'h12, 0, 32'h0000_00e1);
		add_entry(1, LBU,    5'd11, 0, 0, 0, 32'h13, 0, 32'h0000_00f0);
		add_entry(1, LH,     5'd12, 0, 0, 0, 32'h10, 0, 32'hffff_d2c3);
		add_entry(1, LH,     5'd13, 0, 0, 0, 32'h13, 0, 32'hffff_f0e1);
		add_entry(1, LHU,    5'd14, 0, 0, 0, 32'h12, 0, 32'h0000_f0e1);
		add_entry(1, LH,     5'd16, 0, 0, 0, 32'h0a, 0, 32'h0000_7702);
		add_entry(1, LW,     5'd17, 0, 0, 0, 32'h13, 0, 32'hf0e1_d2c3);
		add_entry(1, ALU,    5'd31, 32'hcafe_f00d, 0, 0, 0, 0, 32'hcafe_f00d);
		add_entry(1, NOP,    5'd0,  0, 0, 0, 0, 0, 0);
	endtask

	// host transfers start and end 2 ns after a rising edge.
	task automatic host_access(input logic we, input logic [`EXMEM_RAM_AW-1:0] addr,
		input logic [`EXMEM_DATA_W-1:0] data);
		host_req   = 1'b1;
		host_we    = we;
		host_addr  = addr;
		host_be    = 4'hf;
		host_wdata = data;
		@(negedge clk);
		while (!host_gnt) begin
			@(negedge clk);
		end
		if (we) begin
			ram_model[addr] = data;
			known[addr]     = 1'b1;
		end
		@(posedge clk);
		#2;
		host_req = 1'b0;
		if (!we) begin
			@(negedge clk);
			if (!host_rvalid) begin
				report_error("host_rvalid did not arrive one cycle after the read grant");
			end
			if (known[addr]) begin
				check_word(addr, host_rdata, ram_model[addr]);
			end
			@(posedge clk);
			#2;
		end
	endtask

	// random traffic stays in the upper half of the RAM, away from the table.
	task automatic host_background();
		logic                     we;
		logic [6:0]               offset;
		logic [`EXMEM_DATA_W-1:0] data;
		while (bg_on) begin
			if (take_bit()) begin
				we     = take_bit();
				offset = 7'(take_bits(7));
				data   = take_bits(32);
				host_access(we, {1'b1, offset}, data);
			end else begin
				@(posedge clk);
				#2;
			end
		end
	endtask

	task automatic offer(input entry_t e);
		wb_result_t x;
		ex_valid    = e.valid;
		ex_op       = e.op;
		ex_waddr    = e.waddr;
		ex_wdata    = e.wdata;
		ex_hi       = e.hi;
		ex_lo       = e.lo;
		ex_ram_addr = e.addr;
		ex_reg2     = e.reg2;
		@(negedge clk);
		while (stall) begin
			@(negedge clk);
		end
		if (e.valid) begin
			x       = '0;
			x.valid = 1'b1;
			x.we    = e.op inside {ALU, LB, LBU, LH, LHU, LW};
			x.whilo = (e.op == MTHILO);
			x.waddr = e.waddr;
			x.wdata = e.exp;
			x.hi    = e.hi;
			x.lo    = e.lo;
			exp_q.push_back(x);
			due_q.push_back((e.op inside {NOP, ALU, MTHILO}) ? cycle + 2 : -1);
			if (e.op inside {SB, SH, SW}) begin
				model_store(e.op, e.addr, e.reg2);
			end
		end
		@(posedge clk);
		#2;
	endtask

	task automatic run_table();
		for (int i = 0; i < TABLE_LEN; i++) begin
			offer(tbl[i]);
		end
		ex_valid = 1'b0;
		ex_op    = NOP;
	endtask

	task automatic wait_drain();
		while (n_checked != exp_q.size()) begin
			@(negedge clk);
		end
		@(posedge clk);
		#2;
	endtask

	initial begin
		cycle = 0;
		forever begin
			@(posedge clk);
			cycle++;
			if (cycle > CYCLE_LIMIT) begin
				$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
				$display("Result: FAILED");
				$fatal(1, "timeout");
			end
		end
	end

	initial begin
		wb_result_t got;
		int         due;
		n_checked = 0;
		forever begin
			@(negedge clk);
			if (reset_n && wb_valid) begin
				if (n_checked >= exp_q.size()) begin
					report_error("a writeback appeared with no op outstanding");
				end
				got = '{valid: wb_valid, we: wb_we, waddr: wb_waddr, wdata: wb_wdata,
					whilo: wb_whilo, hi: wb_hi, lo: wb_lo};
				check_wb(got, exp_q[n_checked]);
				due = due_q[n_checked];
				if (due >= 0 && due != cycle) begin
					report_error($sformatf("CHECK FAILED at %0t: writeback in cycle %0d, expected %0d",
						$time, cycle, due));
				end
				n_checked++;
			end
		end
	end

	initial begin
		reset_n     = 1'b0;
		ex_valid    = 1'b0;
		ex_op       = NOP;
		ex_waddr    = '0;
		ex_wdata    = '0;
		ex_hi       = '0;
		ex_lo       = '0;
		ex_ram_addr = '0;
		ex_reg2     = '0;
		host_req    = 1'b0;
		host_we     = 1'b0;
		host_addr   = '0;
		host_be     = '0;
		host_wdata  = '0;
		bg_on       = 1'b0;
		known       = '0;
		lfsr        = 32'h7a88_750d;
		fill_table();
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		reset_n = 1'b1;
		@(negedge clk);
		check_flag("stall", stall, 1'b0);
		check_flag("wb_valid", wb_valid, 1'b0);
		check_flag("host_gnt", host_gnt, 1'b0);
		@(posedge clk);
		#2;
		host_access(1'b1, 8'd4, 32'hf0e1_d2c3);
		run_table();
		wait_drain();
		for (int w = 0; w < 8; w++) begin
			if (known[w]) begin
				host_access(1'b0, 8'(w), '0);
			end
		end
		// second pass of the same table while the host competes for the RAM.
		bg_on = 1'b1;
		fork
			begin
				run_table();
				bg_on = 1'b0;
			end
			host_background();
		join
		wait_drain();
		if (i_exmem_slice.i_props.fail_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
